/* imu_pkg.sv */
package imu_pkg;

    // ------------------------------------------------------------
    // Sensor sample types
    // ------------------------------------------------------------

    // One signed axis reading as delivered by the IMU controller
    typedef logic signed [15:0] axis_t;

    // Quaternion with w in the top bits so it packs high field first
    typedef struct packed {
        axis_t w;
        axis_t x;
        axis_t y;
        axis_t z;
    } quat_t;

    // Angular rate on the three axes
    typedef struct packed {
        axis_t x;
        axis_t y;
        axis_t z;
    } gyro_t;

    // Bit order matches the flags byte of the SPI packet
    // Bit 0 is quat_valid and bit 3 is error, the top nibble stays zero
    typedef struct packed {
        logic [3:0] reserved;
        logic       error;
        logic       initialized;
        logic       gyro_valid;
        logic       quat_valid;
    } imu_flags_t;

    // Everything handed from the input stage to the snapshot, 120 bits
    typedef struct packed {
        quat_t      quat;
        gyro_t      gyro;
        imu_flags_t flags;
    } imu_sample_t;

endpackage

/* spi_pkg.sv */
package spi_pkg;

    // ------------------------------------------------------------
    // Packet format seen by the SPI master
    // ------------------------------------------------------------

    // Header, 4 quaternion axes, 3 gyro axes and the flags byte
    localparam int packet_bytes = 16;
    localparam int packet_bits  = packet_bytes * 8;

    // One byte on the wire
    typedef logic [7:0] spi_byte_t;

    // First byte of every packet, lets the MCU find frame alignment
    localparam spi_byte_t header_byte = 8'hAA;

    // Whole packet with byte 0 in the top bits
    // Bit packet_bits-1 is the first bit driven on sdo
    typedef logic [packet_bits-1:0] spi_packet_t;

    // ------------------------------------------------------------
    // Shifter bookkeeping
    // ------------------------------------------------------------

    // Number of bits already sent in this transaction
    // Wide enough to hold packet_bits itself, where the count stops
    typedef logic [7:0] bit_index_t;

endpackage

/* imu_input_sync.sv */
`timescale 1ns/1ps

module imu_input_sync
    import imu_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic        clk,
    input  logic        cs_n,
    input  imu_sample_t sensor_in,
    output imu_sample_t sample_sync
);

    // ------------------------------------------------------------
    // Input registers
    // ------------------------------------------------------------

    // Data words are only sampled later, once a valid flag has been seen,
    // so one register stage is enough to take them off the input pins
    quat_t      quat_q = '0;
    gyro_t      gyro_q = '0;
    imu_flags_t flags_q = '0;

    always_ff @(posedge clk) begin
        quat_q  <= sensor_in.quat;
        gyro_q  <= sensor_in.gyro;
        // Reserved input bits are dropped here
        flags_q <= '{reserved: '0,
                     error: sensor_in.flags.error,
                     initialized: sensor_in.flags.initialized,
                     gyro_valid: sensor_in.flags.gyro_valid,
                     quat_valid: sensor_in.flags.quat_valid};
    end

    // ------------------------------------------------------------
    // Flag and chip-select synchronizers
    // ------------------------------------------------------------

    imu_flags_t [SYNC_STAGES-1:0] flags_sync = '0;
    logic [SYNC_STAGES-1:0]       cs_n_sync = '0;
    logic                         cs_n_prev = 1'b0;
    imu_flags_t                   flags_s;
    logic                         cs_high;
    logic                         cs_rise;

    always_ff @(posedge clk) begin
        flags_sync <= {flags_sync[SYNC_STAGES-2:0], flags_q};
        cs_n_sync  <= {cs_n_sync[SYNC_STAGES-2:0], cs_n};
        cs_n_prev  <= cs_n_sync[SYNC_STAGES-1];
    end

    assign flags_s = flags_sync[SYNC_STAGES-1];
    assign cs_high = cs_n_sync[SYNC_STAGES-1];
    // First clk cycle after the end of a transaction is seen
    assign cs_rise = cs_high && !cs_n_prev;

    // ------------------------------------------------------------
    // Valid latches
    // ------------------------------------------------------------

    logic quat_latch = 1'b0;
    logic gyro_latch = 1'b0;

    // The controller may only pulse its valids for one cycle, so each one
    // is held until the master has had a chance to read it
    // On the end of a transaction the old state is dropped, but a flag that
    // is high in that very cycle still gets recorded
    always_ff @(posedge clk) begin
        if (cs_rise) begin
            quat_latch <= flags_s.quat_valid;
            gyro_latch <= flags_s.gyro_valid;
        end else if (cs_high) begin
            quat_latch <= quat_latch | flags_s.quat_valid;
            gyro_latch <= gyro_latch | flags_s.gyro_valid;
        end
        // While cs_n is low both latches keep their value
    end

    // Status levels pass straight from the synchronizer
    assign sample_sync = '{quat: quat_q,
                           gyro: gyro_q,
                           flags: '{reserved: flags_s.reserved,
                                    error: flags_s.error,
                                    initialized: flags_s.initialized,
                                    gyro_valid: gyro_latch,
                                    quat_valid: quat_latch}};

endmodule

/* imu_snapshot.sv */
`timescale 1ns/1ps

module imu_snapshot
    import imu_pkg::*;
    import spi_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic        clk,
    input  logic        cs_n,
    input  imu_sample_t sample_sync,
    output spi_packet_t tx_packet
);

    // ------------------------------------------------------------
    // Chip-select synchronizer
    // ------------------------------------------------------------

    logic [SYNC_STAGES-1:0] cs_n_sync = '0;
    logic                   cs_idle;

    always_ff @(posedge clk) begin
        cs_n_sync <= {cs_n_sync[SYNC_STAGES-2:0], cs_n};
    end

    // High while no transaction is running, as seen from the clk domain
    assign cs_idle = cs_n_sync[SYNC_STAGES-1];

    // ------------------------------------------------------------
    // Gated snapshot
    // ------------------------------------------------------------

    quat_t      quat_snap = '0;
    gyro_t      gyro_snap = '0;
    imu_flags_t flags_snap = '0;

    // Between transactions the snapshot tracks the newest data, but a data
    // group only moves when its valid latch says the words are fresh
    // Otherwise the last good reading is kept instead of stale registers
    // Once cs_n low has crossed the synchronizer everything stays frozen,
    // so the sck-domain shifter reads a packet that cannot change under it
    always_ff @(posedge clk) begin
        if (cs_idle) begin
            if (sample_sync.flags.quat_valid) begin
                quat_snap <= sample_sync.quat;
            end
            if (sample_sync.flags.gyro_valid) begin
                gyro_snap <= sample_sync.gyro;
            end
            // Flags always follow, so a missing update shows up as valid 0
            flags_snap <= sample_sync.flags;
        end
    end

    // ------------------------------------------------------------
    // Packet assembly
    // ------------------------------------------------------------

    spi_byte_t flags_byte;

    // Upper nibble is forced to zero on the wire
    assign flags_byte = {4'h0,
                         flags_snap.error,
                         flags_snap.initialized,
                         flags_snap.gyro_valid,
                         flags_snap.quat_valid};

    // Each axis is 16 bits, so concatenation puts its high byte first
    assign tx_packet = {
        header_byte,
        quat_snap.w,
        quat_snap.x,
        quat_snap.y,
        quat_snap.z,
        gyro_snap.x,
        gyro_snap.y,
        gyro_snap.z,
        flags_byte
    };

endmodule

/* spi_miso_shifter.sv */
`timescale 1ns/1ps

module spi_miso_shifter
    import spi_pkg::*;
(
    input  logic        sck,
    input  logic        cs_n,
    input  spi_packet_t tx_packet,
    output logic        sdo
);

    // Width of a bit position inside the packet
    localparam int SEL_W = $clog2(packet_bits);

    // ------------------------------------------------------------
    // Transaction state, cleared whenever cs_n is high
    // ------------------------------------------------------------

    logic             started;
    bit_index_t       bit_cnt;
    logic             done;
    logic [SEL_W-1:0] bit_sel;

    // Mode 0 means the master samples on the rising edge
    // Bit 127 is already on sdo when cs_n falls, so nothing may advance
    // before the master has taken that first sample
    always_ff @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    // Next bit is set up on the falling edge, half a period before it is read
    // The count stops at packet_bits so a long read never wraps around
    always_ff @(negedge sck or posedge cs_n) begin
        if (cs_n) begin
            bit_cnt <= '0;
        end else if (started && !done) begin
            bit_cnt <= bit_cnt + bit_index_t'(1);
        end
    end

    assign done = (bit_cnt == bit_index_t'(packet_bits));

    // ------------------------------------------------------------
    // MISO output
    // ------------------------------------------------------------

    // Count n selects packet bit 127 - n, which sends byte 0 first, MSB first
    assign bit_sel = SEL_W'(bit_index_t'(packet_bits - 1) - bit_cnt);

    // Idle line is 0, and so is everything clocked past the last bit
    assign sdo = (cs_n || done) ? 1'b0 : tx_packet[bit_sel];

endmodule

/* imu_spi_top.sv */
`timescale 1ns/1ps

module imu_spi_top
    import imu_pkg::*;
    import spi_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic        clk,
    input  logic        cs_n,
    input  logic        sck,
    input  imu_sample_t sensor_in,
    output logic        sdo
);

    // ------------------------------------------------------------
    // Clock domain crossing between the IMU side and the SPI side
    // ------------------------------------------------------------

    // Registered data with latched valids and synchronized status
    imu_sample_t sample_sync;
    // Frozen packet while cs_n is low
    spi_packet_t tx_packet;

    // Registers the controller outputs and holds the valid pulses
    imu_input_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) input_sync_i (
        .clk        (clk),
        .cs_n       (cs_n),
        .sensor_in  (sensor_in),
        .sample_sync(sample_sync)
    );

    // Tracks the latest valid data and freezes it for the transaction
    imu_snapshot #(
        .SYNC_STAGES(SYNC_STAGES)
    ) snapshot_i (
        .clk        (clk),
        .cs_n       (cs_n),
        .sample_sync(sample_sync),
        .tx_packet  (tx_packet)
    );

    // Runs purely on sck and cs_n from the MCU
    spi_miso_shifter shifter_i (
        .sck      (sck),
        .cs_n     (cs_n),
        .tx_packet(tx_packet),
        .sdo      (sdo)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    // Free-running clk for the IMU side, starting low at time zero
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

/* tb_imu_spi.sv */
`timescale 1ns/1ps

module tb_imu_spi
    import imu_pkg::*;
    import spi_pkg::*;
;

    // Watchdog budget is 160 SPI bits at 40 ns per test plus 20 us for the clk-side waits
    localparam int num_tests  = 6;
    localparam int timeout_ns = num_tests * 160 * 40 + 20000;

    logic        clk;
    logic        cs_n;
    logic        sck;
    logic        sdo;
    imu_sample_t sensor_in;
    logic [31:0] rng_state = 32'd96;
    quat_t       qa, qb, qc;
    gyro_t       ga, gb, gc;
    spi_packet_t rx, exp_pkt;
    spi_byte_t   extra;

    tb_clock_gen #(.PERIOD_NS(8)) clock_i (.clk(clk));

    imu_spi_top dut_i (
        .clk      (clk),
        .cs_n     (cs_n),
        .sck      (sck),
        .sensor_in(sensor_in),
        .sdo      (sdo)
    );

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------

    // Linear congruential generator that returns one 16-bit axis per call
    function automatic axis_t random_axis();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:15];
    endfunction

    function automatic quat_t random_quat();
        return '{w: random_axis(), x: random_axis(), y: random_axis(), z: random_axis()};
    endfunction

    function automatic gyro_t random_gyro();
        return '{x: random_axis(), y: random_axis(), z: random_axis()};
    endfunction

    // Builds the packet the MCU should see byte by byte from the wire format
    function automatic spi_packet_t expected_packet(quat_t q, gyro_t g, logic qv, logic gv,
                                                    logic init, logic err);
        spi_byte_t   b [16];
        axis_t       ax [7];
        spi_packet_t p;
        ax = '{q.w, q.x, q.y, q.z, g.x, g.y, g.z};
        b[0] = 8'hAA;
        for (int k = 0; k < 7; k++) begin
            b[1 + 2 * k] = ax[k][15:8];
            b[2 + 2 * k] = ax[k][7:0];
        end
        b[15] = {4'b0000, err, init, gv, qv};
        for (int i = 0; i < 16; i++) begin
            p[127 - 8 * i -: 8] = b[i];
        end
        return p;
    endfunction

    // Drives one sample with the valids high for a single clk cycle only
    // Reserved bits are set to show that they never reach the packet
    task automatic apply_sample(quat_t q, gyro_t g, logic init, logic err,
                                logic pulse_q, logic pulse_g);
        @(posedge clk);
        #1;
        sensor_in = '{quat: q, gyro: g,
                      flags: '{reserved: 4'hF, error: err, initialized: init,
                               gyro_valid: pulse_g, quat_valid: pulse_q}};
        @(posedge clk);
        #1;
        sensor_in.flags.quat_valid = 1'b0;
        sensor_in.flags.gyro_valid = 1'b0;
        // Long enough for the synchronizer, latch and snapshot to settle
        repeat (8) @(posedge clk);
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------

    task automatic check_packet(spi_packet_t got, spi_packet_t exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "packet mismatch");
        end
    endtask

    task automatic check_byte(spi_byte_t got, spi_byte_t exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %b expected %b", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "sdo mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // SPI master, mode 0
    // ------------------------------------------------------------

    // sdo is taken just before each rising sck edge, half a period after
    // the slave moved it on the falling edge
    // Bits past 128 land in extra, MSB first
    task automatic spi_read(int nbits, output spi_packet_t data, output spi_byte_t over);
        data = '0;
        over = '0;
        @(posedge clk);
        #1;
        cs_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        for (int i = 0; i < nbits; i++) begin
            #20;
            if (i < 128) begin
                data[127 - i] = sdo;
            end else if (i < 136) begin
                over[135 - i] = sdo;
            end
            sck = 1'b1;
            #20;
            sck = 1'b0;
        end
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        repeat (8) @(posedge clk);
        check_bit(sdo, 1'b0, "sdo with cs_n high");
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------

    task automatic test_valid_read();
        qa = random_quat();
        ga = random_gyro();
        apply_sample(qa, ga, 1'b0, 1'b0, 1'b1, 1'b1);
        spi_read(128, rx, extra);
        check_byte(rx[127 -: 8], 8'hAA, "header byte");
        check_byte(rx[7:0], 8'h03, "flags after both valids");
        check_packet(rx, expected_packet(qa, ga, 1'b1, 1'b1, 1'b0, 1'b0), "fresh packet");
    endtask

    // Latches were cleared by the end of the last read, so nothing reloads
    task automatic test_stale_read();
        qb = random_quat();
        gb = random_gyro();
        apply_sample(qb, gb, 1'b0, 1'b0, 1'b0, 1'b0);
        spi_read(128, rx, extra);
        check_packet(rx, expected_packet(qa, ga, 1'b0, 1'b0, 1'b0, 1'b0), "stale packet");
    endtask

    task automatic test_status_levels();
        apply_sample(qb, gb, 1'b1, 1'b0, 1'b0, 1'b0);
        spi_read(128, rx, extra);
        check_byte(rx[7:0], 8'h04, "flags with initialized");
        check_packet(rx, expected_packet(qa, ga, 1'b0, 1'b0, 1'b1, 1'b0),
                     "initialized packet");
        // Only the quaternion group moves here
        apply_sample(qb, gb, 1'b0, 1'b1, 1'b1, 1'b0);
        spi_read(128, rx, extra);
        check_byte(rx[7:0], 8'h09, "flags with error and quat valid");
        check_packet(rx, expected_packet(qb, ga, 1'b1, 1'b0, 1'b0, 1'b1), "error packet");
    endtask

    // A valid pulse during the read is not latched, but the latches from
    // before the read stay set through the first idle clk cycle, so the
    // snapshot takes the new registered data just once as cs_n returns high
    task automatic test_update_during_read();
        apply_sample(qb, gb, 1'b0, 1'b1, 1'b1, 1'b1);
        qc = random_quat();
        gc = random_gyro();
        exp_pkt = expected_packet(qb, gb, 1'b1, 1'b1, 1'b0, 1'b1);
        fork
            spi_read(128, rx, extra);
            begin
                repeat (40) @(posedge clk);
                apply_sample(qc, gc, 1'b0, 1'b1, 1'b1, 1'b1);
            end
        join
        check_packet(rx, exp_pkt, "packet frozen during read");
        spi_read(128, rx, extra);
        check_packet(rx, expected_packet(qc, gc, 1'b0, 1'b0, 1'b0, 1'b1),
                     "packet after update");
    endtask

    task automatic test_overrun();
        spi_read(136, rx, extra);
        check_packet(rx, expected_packet(qc, gc, 1'b0, 1'b0, 1'b0, 1'b1),
                     "packet before overrun");
        check_byte(extra, 8'h00, "bits past the packet");
    endtask

    task automatic test_partial_read();
        exp_pkt = expected_packet(qc, gc, 1'b0, 1'b0, 1'b0, 1'b1);
        spi_read(40, rx, extra);
        for (int i = 0; i < 5; i++) begin
            check_byte(rx[127 - 8 * i -: 8], exp_pkt[127 - 8 * i -: 8], "partial read byte");
        end
        spi_read(128, rx, extra);
        check_packet(rx, exp_pkt, "full read after partial");
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------

    initial begin
        cs_n = 1'b1;
        sck = 1'b0;
        sensor_in = '0;
        // cs_n high for 16 cycles clears the shifter and flushes the clk side
        repeat (16) @(posedge clk);
        check_bit(sdo, 1'b0, "sdo after reset");
        test_valid_read();
        test_stale_read();
        test_status_levels();
        test_update_during_read();
        test_overrun();
        test_partial_read();
        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

/* filelist.f */
imu_pkg.sv
spi_pkg.sv
imu_input_sync.sv
imu_snapshot.sv
spi_miso_shifter.sv
imu_spi_top.sv
tb_clock_gen.sv
tb_imu_spi.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_imu_spi -f filelist.f -o sim_imu_spi
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_imu_spi 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q -F ">>> PASS"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
